// File: hdl/flash_shadow_pkg.sv
// flash shadow package with shared width types, copy states and default parameters
package flash_shadow_pkg;

  // 21-bit word address on the flash pads
  typedef logic [20:0] flash_addr_t;

  // flash and internal bus data word
  typedef logic [15:0] flash_word_t;

  // wishbone word address, bits 16 to 1 of a byte address
  typedef logic [15:0] bus_addr_t;

  // page base number for the paged window
  typedef logic [11:0] page_t;

  // copy engine states
  typedef enum logic [2:0] {
    COPY_IDLE      = 3'd0,
    COPY_LOAD_BASE = 3'd1,
    COPY_READ      = 3'd2,
    COPY_STORE     = 3'd3,
    COPY_DONE      = 3'd4
  } copy_state_t;

  // ack wait in clocks, two at least for the shifter
  localparam int DEF_ACK_WAIT = 2;

  // shadow ram address width, 256 words
  localparam int DEF_SHADOW_AW = 8;

endpackage

// File: hdl/flash_cntrl.sv
// flash controller, wishbone slave mapping linear and paged windows onto nor flash pads
`timescale 1ns/1ns

module flash_cntrl #(
  parameter int ACK_WAIT = flash_shadow_pkg::DEF_ACK_WAIT
) (
  input  logic                        wb_clk_i,
  input  logic                        reset_i,
  input  flash_shadow_pkg::flash_word_t wb_dat_i,
  output flash_shadow_pkg::flash_word_t wb_dat_o,
  input  flash_shadow_pkg::bus_addr_t   wb_adr_i,
  input  logic                        wb_we_i,
  input  logic                        wb_tga_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_cyc_i,
  output logic                        wb_ack_o,
  output flash_shadow_pkg::flash_addr_t flash_addr_o,
  input  flash_shadow_pkg::flash_word_t flash_data_i,
  output logic                        flash_we_n_o,
  output logic                        flash_ce2_o
);

  // page base for the paged window
  flash_shadow_pkg::page_t base_q;
  // ack wait shifter, one travels up to the top bit
  logic [ACK_WAIT-1:0]     sft_q;
  logic                    op;
  logic                    op_base;

  // access in progress
  assign op       = wb_cyc_i & wb_stb_i;
  // write to the base register
  assign op_base  = op & wb_tga_i & wb_we_i;

  // read data straight from the pads
  assign wb_dat_o = flash_data_i;
  // no programming, write enable parked inactive
  assign flash_we_n_o = 1'b1;
  // top of shifter is the ack pulse
  assign wb_ack_o = sft_q[ACK_WAIT-1];

  // pad address, one clock behind the bus
  always_ff @(posedge wb_clk_i) begin
    if (wb_tga_i) begin
      // paged window, bit 20 set, base page, low byte of bus address
      flash_addr_o <= {1'b1, base_q, wb_adr_i[7:0]};
    end else begin
      // linear window, low 64K words
      flash_addr_o <= {5'h00, wb_adr_i};
    end
  end

  // chip enable follows the access
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      flash_ce2_o <= 1'b0;
    end else begin
      flash_ce2_o <= op;
    end
  end

  // ack wait shifter
  always_ff @(posedge wb_clk_i) begin
    if (reset_i || !op) begin
      sft_q <= '0;
    end else if (|sft_q) begin
      // already counting, just shift
      sft_q <= {sft_q[ACK_WAIT-2:0], 1'b0};
    end else begin
      // new access, inject a one
      sft_q <= {sft_q[ACK_WAIT-2:0], 1'b1};
    end
  end

  // base loads on the edge that raises ack
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      base_q <= '0;
    end else if (op_base && sft_q[ACK_WAIT-2]) begin
      base_q <= wb_dat_i[11:0];
    end
  end

endmodule

// File: hdl/shadow_word_counter.sv
// word index counter for the shadow copy, with clear, step and last-word flag
`timescale 1ns/1ns

module shadow_word_counter #(
  parameter int SHADOW_AW = flash_shadow_pkg::DEF_SHADOW_AW
) (
  input  logic                 wb_clk_i,
  input  logic                 reset_i,
  input  logic                 clr_i,
  input  logic                 step_i,
  output logic [SHADOW_AW-1:0] idx_o,
  output logic                 last_o
);

  // index of the word being copied
  logic [SHADOW_AW-1:0] idx_q;

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      idx_q <= '0;
    end else if (clr_i) begin
      // new copy starts at word zero
      idx_q <= '0;
    end else if (step_i) begin
      // wraps to zero past the last word
      idx_q <= idx_q + 1'b1;
    end
  end

  assign idx_o  = idx_q;

  // final word of the block, all ones
  assign last_o = &idx_q;

endmodule

// File: hdl/shadow_copy_fsm.sv
// copy state machine, reads one block from flash over the bus and stores it in the shadow ram
`timescale 1ns/1ns

module shadow_copy_fsm #(
  parameter int SHADOW_AW = flash_shadow_pkg::DEF_SHADOW_AW
) (
  input  logic                          wb_clk_i,
  input  logic                          reset_i,
  input  logic                          start_i,
  input  logic                          paged_i,
  input  flash_shadow_pkg::page_t       page_i,
  input  flash_shadow_pkg::bus_addr_t   src_i,
  output logic                          busy_o,
  output logic                          done_o,
  output logic                          bus_cyc_o,
  output logic                          bus_stb_o,
  output logic                          bus_we_o,
  output logic                          bus_tga_o,
  output flash_shadow_pkg::bus_addr_t   bus_adr_o,
  output flash_shadow_pkg::flash_word_t bus_dat_o,
  input  flash_shadow_pkg::flash_word_t bus_dat_i,
  input  logic                          bus_ack_i,
  output logic                          cnt_clr_o,
  output logic                          cnt_step_o,
  input  logic [SHADOW_AW-1:0]          cnt_idx_i,
  input  logic                          cnt_last_i,
  output logic                          ram_we_o,
  output flash_shadow_pkg::flash_word_t ram_wdata_o
);

  flash_shadow_pkg::copy_state_t state_q;
  flash_shadow_pkg::copy_state_t state_d;

  // request latched at start
  logic                          paged_q;
  flash_shadow_pkg::page_t       page_q;
  flash_shadow_pkg::bus_addr_t   src_q;
  // word captured on ack
  flash_shadow_pkg::flash_word_t word_q;
  // one idle bus cycle after each ack
  logic                          gap_q;
  logic                          in_access;
  logic                          ack_seen;
  flash_shadow_pkg::bus_addr_t   idx_ext;

  // index widened to a bus address
  assign idx_ext   = flash_shadow_pkg::bus_addr_t'(cnt_idx_i);

  // states that own the bus
  assign in_access = (state_q == flash_shadow_pkg::COPY_LOAD_BASE) ||
                     (state_q == flash_shadow_pkg::COPY_READ);
  assign ack_seen  = bus_ack_i & bus_cyc_o;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      flash_shadow_pkg::COPY_IDLE: begin
        // start ignored anywhere else
        if (start_i) begin
          state_d = paged_i ? flash_shadow_pkg::COPY_LOAD_BASE : flash_shadow_pkg::COPY_READ;
        end
      end
      flash_shadow_pkg::COPY_LOAD_BASE: begin
        if (ack_seen) begin
          state_d = flash_shadow_pkg::COPY_READ;
        end
      end
      flash_shadow_pkg::COPY_READ: begin
        if (ack_seen) begin
          state_d = flash_shadow_pkg::COPY_STORE;
        end
      end
      flash_shadow_pkg::COPY_STORE: begin
        state_d = cnt_last_i ? flash_shadow_pkg::COPY_DONE : flash_shadow_pkg::COPY_READ;
      end
      flash_shadow_pkg::COPY_DONE: begin
        state_d = flash_shadow_pkg::COPY_IDLE;
      end
      default: begin
        state_d = flash_shadow_pkg::COPY_IDLE;
      end
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      state_q <= flash_shadow_pkg::COPY_IDLE;
      gap_q   <= 1'b0;
      paged_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // drop cyc for a cycle after every ack
      gap_q   <= ack_seen;
      if (state_q == flash_shadow_pkg::COPY_IDLE && start_i) begin
        paged_q <= paged_i;
      end
    end
  end

  // page and source held for the whole copy
  always_ff @(posedge wb_clk_i) begin
    if (state_q == flash_shadow_pkg::COPY_IDLE && start_i) begin
      page_q <= page_i;
      src_q  <= src_i;
    end
    if (state_q == flash_shadow_pkg::COPY_READ && ack_seen) begin
      word_q <= bus_dat_i;
    end
  end

  // bus request
  assign bus_cyc_o = in_access & ~gap_q;
  assign bus_stb_o = bus_cyc_o;
  // only the base load writes
  assign bus_we_o  = (state_q == flash_shadow_pkg::COPY_LOAD_BASE);
  assign bus_tga_o = in_access & paged_q;
  // paged reads index the page, linear reads offset the source
  assign bus_adr_o = paged_q ? idx_ext : src_q + idx_ext;
  // base page on the low data bits
  assign bus_dat_o = {4'h0, page_q};

  // counter control
  assign cnt_clr_o  = (state_q == flash_shadow_pkg::COPY_IDLE) & start_i;
  assign cnt_step_o = (state_q == flash_shadow_pkg::COPY_STORE);

  // ram write of the captured word
  assign ram_we_o    = (state_q == flash_shadow_pkg::COPY_STORE);
  assign ram_wdata_o = word_q;

  // busy falls as done pulses
  assign busy_o = in_access | (state_q == flash_shadow_pkg::COPY_STORE);
  assign done_o = (state_q == flash_shadow_pkg::COPY_DONE);

endmodule

// File: hdl/shadow_ram.sv
// shadow ram, dual-port array holding the copied image with a registered host read
`timescale 1ns/1ns

module shadow_ram #(
  parameter int SHADOW_AW = flash_shadow_pkg::DEF_SHADOW_AW
) (
  input  logic                          wb_clk_i,
  input  logic                          we_i,
  input  logic [SHADOW_AW-1:0]          waddr_i,
  input  flash_shadow_pkg::flash_word_t wdata_i,
  input  logic [SHADOW_AW-1:0]          raddr_i,
  output flash_shadow_pkg::flash_word_t rdata_o
);

  // shadowed image, one word per index
  flash_shadow_pkg::flash_word_t mem [2**SHADOW_AW];

  // write port from the copy engine
  always_ff @(posedge wb_clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // host read, one clock latency
  always_ff @(posedge wb_clk_i) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

// File: hdl/flash_shadow_top.sv
// flash shadow top, copy engine moving a flash block into the shadow ram
`timescale 1ns/1ns

module flash_shadow_top #(
  parameter int ACK_WAIT  = flash_shadow_pkg::DEF_ACK_WAIT,
  parameter int SHADOW_AW = flash_shadow_pkg::DEF_SHADOW_AW
) (
  input  logic                          wb_clk_i,
  input  logic                          reset_i,
  input  logic                          start_i,
  input  logic                          paged_i,
  input  flash_shadow_pkg::page_t       page_i,
  input  flash_shadow_pkg::bus_addr_t   src_i,
  output logic                          busy_o,
  output logic                          done_o,
  input  logic [SHADOW_AW-1:0]          rd_addr_i,
  output flash_shadow_pkg::flash_word_t rd_data_o,
  output flash_shadow_pkg::flash_addr_t flash_addr_o,
  input  flash_shadow_pkg::flash_word_t flash_data_i,
  output logic                          flash_we_n_o,
  output logic                          flash_ce2_o
);

  // internal wishbone bus
  logic                          bus_cyc;
  logic                          bus_stb;
  logic                          bus_we;
  logic                          bus_tga;
  flash_shadow_pkg::bus_addr_t   bus_adr;
  flash_shadow_pkg::flash_word_t bus_dat_w;
  flash_shadow_pkg::flash_word_t bus_dat_r;
  logic                          bus_ack;

  // word counter
  logic                          cnt_clr;
  logic                          cnt_step;
  logic [SHADOW_AW-1:0]          cnt_idx;
  logic                          cnt_last;

  // ram write side
  logic                          ram_we;
  flash_shadow_pkg::flash_word_t ram_wdata;

  shadow_copy_fsm #(
    .SHADOW_AW (SHADOW_AW)
  ) i_fsm (
    .wb_clk_i    (wb_clk_i),
    .reset_i     (reset_i),
    .start_i     (start_i),
    .paged_i     (paged_i),
    .page_i      (page_i),
    .src_i       (src_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .bus_cyc_o   (bus_cyc),
    .bus_stb_o   (bus_stb),
    .bus_we_o    (bus_we),
    .bus_tga_o   (bus_tga),
    .bus_adr_o   (bus_adr),
    .bus_dat_o   (bus_dat_w),
    .bus_dat_i   (bus_dat_r),
    .bus_ack_i   (bus_ack),
    .cnt_clr_o   (cnt_clr),
    .cnt_step_o  (cnt_step),
    .cnt_idx_i   (cnt_idx),
    .cnt_last_i  (cnt_last),
    .ram_we_o    (ram_we),
    .ram_wdata_o (ram_wdata)
  );

  shadow_word_counter #(
    .SHADOW_AW (SHADOW_AW)
  ) i_cnt (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .clr_i    (cnt_clr),
    .step_i   (cnt_step),
    .idx_o    (cnt_idx),
    .last_o   (cnt_last)
  );

  flash_cntrl #(
    .ACK_WAIT (ACK_WAIT)
  ) i_flash (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .wb_dat_i     (bus_dat_w),
    .wb_dat_o     (bus_dat_r),
    .wb_adr_i     (bus_adr),
    .wb_we_i      (bus_we),
    .wb_tga_i     (bus_tga),
    .wb_stb_i     (bus_stb),
    .wb_cyc_i     (bus_cyc),
    .wb_ack_o     (bus_ack),
    .flash_addr_o (flash_addr_o),
    .flash_data_i (flash_data_i),
    .flash_we_n_o (flash_we_n_o),
    .flash_ce2_o  (flash_ce2_o)
  );

  // ram written at the counter index
  shadow_ram #(
    .SHADOW_AW (SHADOW_AW)
  ) i_ram (
    .wb_clk_i (wb_clk_i),
    .we_i     (ram_we),
    .waddr_i  (cnt_idx),
    .wdata_i  (ram_wdata),
    .raddr_i  (rd_addr_i),
    .rdata_o  (rd_data_o)
  );

endmodule

// File: test/flash_image.svh
// flash image function giving the 16-bit content of any 21-bit flash word address

function automatic flash_shadow_pkg::flash_word_t flash_image(
  input flash_shadow_pkg::flash_addr_t addr
);
  flash_shadow_pkg::flash_word_t mix;
  // low half scrambled by an odd multiplier
  mix = addr[15:0] * 16'h9e37;
  // top address bits folded in so the windows differ
  mix = mix ^ {addr[20:16], addr[20:16], addr[20:15]};
  // byte swapped address keeps neighbouring words apart
  return mix ^ {addr[7:0], addr[15:8]} ^ 16'h3c5a;
endfunction

// File: test/flash_model.sv
// nor flash model driving read data from the flash image, with a write enable watcher
`timescale 1ns/1ns

module flash_model (
  input  logic                          wb_clk_i,
  input  flash_shadow_pkg::flash_addr_t flash_addr_i,
  output flash_shadow_pkg::flash_word_t flash_data_o,
  input  logic                          flash_we_n_i,
  input  logic                          flash_ce2_i,
  output logic                          bad_write_o
);

  `include "flash_image.svh"

  // sticky, set on the first write seen
  logic bad_write_q = 1'b0;

  // pads only carry data while the chip is enabled
  assign flash_data_o = flash_ce2_i ? flash_image(flash_addr_i) : '0;
  assign bad_write_o  = bad_write_q;

  // flash is read only here
  always @(posedge wb_clk_i) begin
    if (flash_we_n_i !== 1'b1) begin
      if (!bad_write_q) begin
        $display("flash model: write enable went low at address 0x%h", flash_addr_i);
      end
      bad_write_q <= 1'b1;
    end
  end

endmodule

// File: test/flash_shadow_tb.sv
// testbench for the flash shadow copy engine with paged and linear copies checked against a reference model
`timescale 1ns/1ns

module flash_shadow_tb;

  localparam int ACK_WAIT      = 3;
  localparam int SHADOW_AW     = flash_shadow_pkg::DEF_SHADOW_AW;
  localparam int SHADOW_WORDS  = 1 << SHADOW_AW;
  localparam int CLK_PERIOD    = 8;
  // one read access plus one store per word
  localparam int COPY_CLKS     = SHADOW_WORDS * (ACK_WAIT + 2);
  // readback takes two clocks a word plus start and reset overhead
  localparam int MARGIN_CLKS   = 3 * SHADOW_WORDS + 64;
  localparam int NUM_COPIES    = 6;
  localparam int WATCHDOG_CLKS = NUM_COPIES * (COPY_CLKS + MARGIN_CLKS);
  localparam int COPY_LIMIT    = COPY_CLKS + 32;

  logic                          wb_clk_i = 1'b0;
  logic                          reset_i;
  logic                          start_i;
  logic                          paged_i;
  flash_shadow_pkg::page_t       page_i;
  flash_shadow_pkg::bus_addr_t   src_i;
  logic [SHADOW_AW-1:0]          rd_addr_i = '0;
  logic                          busy_o;
  logic                          done_o;
  flash_shadow_pkg::flash_word_t rd_data_o;
  flash_shadow_pkg::flash_addr_t flash_addr_o;
  flash_shadow_pkg::flash_word_t flash_data_i;
  logic                          flash_we_n_o;
  logic                          flash_ce2_o;
  logic                          bad_write;

  // error counts kept per process
  int main_errors = 0;
  int cmp_errors  = 0;
  int mon_errors  = 0;
  // readback requests from the main process
  int req_count   = 0;
  int ack_count   = 0;
  logic                        exp_paged = 1'b0;
  flash_shadow_pkg::page_t     exp_page  = '0;
  flash_shadow_pkg::bus_addr_t exp_src   = '0;
  logic   mon_en     = 1'b0;
  integer seed       = 32'hb7adf84a;
  int     test_count = 0;
  int     fail_count = 0;
  int     errs_before;
  string  cur_name;

  `include "flash_image.svh"

  flash_shadow_top #(
    .ACK_WAIT  (ACK_WAIT),
    .SHADOW_AW (SHADOW_AW)
  ) i_dut (
    .wb_clk_i     (wb_clk_i),
    .reset_i      (reset_i),
    .start_i      (start_i),
    .paged_i      (paged_i),
    .page_i       (page_i),
    .src_i        (src_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o),
    .flash_addr_o (flash_addr_o),
    .flash_data_i (flash_data_i),
    .flash_we_n_o (flash_we_n_o),
    .flash_ce2_o  (flash_ce2_o)
  );

  flash_model i_flash_model (
    .wb_clk_i     (wb_clk_i),
    .flash_addr_i (flash_addr_o),
    .flash_data_o (flash_data_i),
    .flash_we_n_i (flash_we_n_o),
    .flash_ce2_i  (flash_ce2_o),
    .bad_write_o  (bad_write)
  );

  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  // expected shadow word for one request and index
  function automatic flash_shadow_pkg::flash_word_t expected_word(
    input logic                        paged,
    input flash_shadow_pkg::page_t     page,
    input flash_shadow_pkg::bus_addr_t src,
    input int                          idx
  );
    flash_shadow_pkg::bus_addr_t   lin;
    flash_shadow_pkg::flash_addr_t fa;
    if (paged) begin
      // one in bit 20 above the page and the word
      fa = {1'b1, page, idx[7:0]};
    end else begin
      // linear window wraps inside the low 64K words
      lin = src + idx[15:0];
      fa  = {5'h00, lin};
    end
    return flash_image(fa);
  endfunction

  function automatic int total_errors();
    return main_errors + cmp_errors + mon_errors;
  endfunction

  task automatic begin_test(input string name);
    cur_name    = name;
    errs_before = total_errors();
  endtask

  task automatic end_test();
    int n;
    assert (!bad_write) else begin
      $display("flash model saw write enable low during test %s", cur_name);
      main_errors++;
    end
    n = total_errors() - errs_before;
    test_count++;
    if (n == 0) begin
      $display("test %s: ok", cur_name);
    end else begin
      fail_count++;
      $display("test %s: failed with %0d errors", cur_name, n);
    end
  endtask

  task automatic apply_reset();
    @(posedge wb_clk_i);
    reset_i <= 1'b1;
    repeat (2) @(posedge wb_clk_i);
    reset_i <= 1'b0;
  endtask

  task automatic check_reset_state();
    @(negedge wb_clk_i);
    assert (busy_o == 1'b0) else begin
      $display("FAILED busy_o: got 0x%h, expected 0x0", busy_o);
      main_errors++;
    end
    assert (done_o == 1'b0) else begin
      $display("FAILED done_o: got 0x%h, expected 0x0", done_o);
      main_errors++;
    end
    assert (flash_ce2_o == 1'b0) else begin
      $display("FAILED flash_ce2_o: got 0x%h, expected 0x0", flash_ce2_o);
      main_errors++;
    end
  endtask

  // one copy with an optional second start pulse at clock poke_cycle
  task automatic run_copy(
    input logic                        paged,
    input flash_shadow_pkg::page_t     page,
    input flash_shadow_pkg::bus_addr_t src,
    input int                          poke_cycle
  );
    int   cycles;
    logic finished;
    logic busy_bad;
    cycles   = 0;
    finished = 1'b0;
    busy_bad = 1'b0;
    @(posedge wb_clk_i);
    start_i <= 1'b1;
    paged_i <= paged;
    page_i  <= page;
    src_i   <= src;
    @(posedge wb_clk_i);
    start_i <= 1'b0;
    while (!finished && cycles < COPY_LIMIT) begin
      @(negedge wb_clk_i);
      cycles++;
      if (done_o) begin
        finished = 1'b1;
        // busy falls in the done cycle
        assert (!busy_o) else begin
          $display("FAILED busy_o: got 0x%h with done_o, expected 0x0", busy_o);
          main_errors++;
        end
      end else if (!busy_bad) begin
        assert (busy_o) else begin
          busy_bad = 1'b1;
          $display("FAILED busy_o: got 0x%h before done_o at clock %0d, expected 0x1",
                   busy_o, cycles);
          main_errors++;
        end
      end
      @(posedge wb_clk_i);
      if (cycles == poke_cycle) begin
        // request that must be ignored
        start_i <= 1'b1;
        paged_i <= ~paged;
        page_i  <= ~page;
        src_i   <= src ^ 16'h5a5a;
      end else begin
        start_i <= 1'b0;
      end
    end
    assert (finished) else begin
      $display("copy did not raise done_o within %0d clocks", COPY_LIMIT);
      main_errors++;
    end
    if (finished) begin
      @(negedge wb_clk_i);
      assert (!done_o) else begin
        $display("FAILED done_o: got 0x%h one clock after done, expected 0x0", done_o);
        main_errors++;
      end
    end
    exp_paged = paged;
    exp_page  = page;
    exp_src   = src;
    req_count++;
    wait (ack_count == req_count);
  endtask

  // reads back every shadow word and compares with the reference
  always begin : compare_ram
    flash_shadow_pkg::flash_word_t exp_word;
    wait (req_count != ack_count);
    for (int i = 0; i < SHADOW_WORDS; i++) begin
      exp_word = expected_word(exp_paged, exp_page, exp_src, i);
      @(posedge wb_clk_i);
      rd_addr_i <= SHADOW_AW'(i);
      @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      assert (rd_data_o == exp_word) else begin
        $display("FAILED rd_data_o at index 0x%0h: got 0x%h, expected 0x%h",
                 i, rd_data_o, exp_word);
        cmp_errors++;
      end
    end
    ack_count++;
  end

  // chip enable off while idle and write enable never asserted
  always @(negedge wb_clk_i) begin
    if (mon_en) begin
      assert (busy_o || !flash_ce2_o) else begin
        $display("FAILED flash_ce2_o: got 0x%h while idle, expected 0x0", flash_ce2_o);
        mon_errors++;
      end
      assert (flash_we_n_o) else begin
        $display("FAILED flash_we_n_o: got 0x%h, expected 0x1", flash_we_n_o);
        mon_errors++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("watchdog expired after %0d clocks, run stopped", WATCHDOG_CLKS);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    logic [31:0]                 rnd;
    flash_shadow_pkg::page_t     page_a;
    flash_shadow_pkg::page_t     page_b;
    flash_shadow_pkg::bus_addr_t src_a;
    reset_i = 1'b1;
    start_i = 1'b0;
    paged_i = 1'b0;
    page_i  = '0;
    src_i   = '0;
    repeat (2) @(posedge wb_clk_i);
    reset_i <= 1'b0;
    mon_en  <= 1'b1;

    begin_test("reset_state");
    check_reset_state();
    end_test();

    begin_test("paged_random");
    rnd    = $random(seed);
    page_a = rnd[11:0];
    run_copy(1'b1, page_a, '0, -1);
    end_test();

    begin_test("linear_random");
    rnd   = $random(seed);
    src_a = rnd[15:0];
    run_copy(1'b0, '0, src_a, -1);
    end_test();

    // source close to the top so the index wraps past 16'hFFFF
    begin_test("linear_wrap");
    rnd   = $random(seed);
    src_a = {9'h1ff, rnd[6:0]};
    run_copy(1'b0, '0, src_a, -1);
    end_test();

    begin_test("paged_page0_after_reset");
    apply_reset();
    check_reset_state();
    run_copy(1'b1, '0, '0, -1);
    end_test();

    begin_test("paged_base_reload");
    rnd    = $random(seed);
    page_b = rnd[11:0];
    if (page_b == '0) begin
      page_b = 12'h5a5;
    end
    run_copy(1'b1, page_b, '0, -1);
    end_test();

    begin_test("start_while_busy");
    rnd    = $random(seed);
    page_a = rnd[11:0];
    run_copy(1'b1, page_a, rnd[31:16], 10);
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", test_count, fail_count,
             total_errors());
    if (total_errors() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: flash_shadow.f
+incdir+test
hdl/flash_shadow_pkg.sv
hdl/flash_cntrl.sv
hdl/shadow_word_counter.sv
hdl/shadow_copy_fsm.sv
hdl/shadow_ram.sv
hdl/flash_shadow_top.sv
test/flash_model.sv
test/flash_shadow_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the flash shadow testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module flash_shadow_tb \
  -f flash_shadow.f \
  -o flash_shadow_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/flash_shadow_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^No errors$" "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1
